// File: sb_rx_stream.f
+incdir+logic
logic/sb_apb_pkg.sv
logic/sb_flit_pkg.sv
logic/sb_apb_regs.sv
logic/sb_flit_fifo.sv
logic/sb_valid_pacer.sv
logic/sb_rx_stream.sv
testbench/sb_rx_stream_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the stream receiver testbench with Verilator and runs it once

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sb_rx_stream.f --top-module sb_rx_stream_tb -o sb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sb_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the testbench prints its verdict on a line of its own
if printf '%s\n' "$sim_out" | grep -qx "Regression passed"; then
    exit 0
else
    exit 1
fi

// File: testbench/sb_rx_stream_tb.sv
/* testbench of the switchboard stream receiver
   pushes a random flit table over APB and checks the stream output in
   every valid mode, under back-pressure and on register errors */
`timescale 1ns/10ps
`default_nettype none
`include "sb_macros.svh"

module sb_rx_stream_tb
    import sb_apb_pkg::*;
    import sb_flit_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int TBL_N           = 24;
    localparam int WATCHDOG_CYCLES = TBL_N * 40 + 500;

    logic                   clk;
    logic                   rst_n;
    logic [`SB_ADDR_W-1:0]  paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    flit_data_t             data;
    flit_dest_t             dest;
    logic                   last;
    logic                   valid;
    wire                    ready;
    logic                   ready_req;
    logic                   rand_ready;
    logic                   rand_bit = 1'b0;

    // stimulus table, each entry is also the expected output in push order
    flit_data_t  tbl_data [TBL_N];
    flit_dest_t  tbl_dest [TBL_N];
    logic        tbl_last [TBL_N];

    // flits accepted by the DUT and not yet seen on the stream
    flit_data_t  exp_data [$];
    flit_dest_t  exp_dest [$];
    logic        exp_last [$];

    int err_count;
    int tests_ok;
    int tests_bad;
    int test_num;
    int b2b_count;

    sb_rx_stream dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .data    (data),
        .dest    (dest),
        .last    (last),
        .valid   (valid),
        .ready   (ready)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ready either follows the main sequence or a fresh random bit each cycle
    always @(negedge clk) rand_bit <= 1'($urandom());
    assign ready = rand_ready ? rand_bit : ready_req;

    task automatic check_data(input string name, input flit_data_t exp, input flit_data_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_dest(input string name, input flit_dest_t exp, input flit_dest_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
            err_count++;
        end
    endtask

    // one APB transfer: setup phase, access phase, then the bus goes idle
    task automatic apb_write(input logic [`SB_ADDR_W-1:0] addr, input logic [31:0] wdata,
                             output logic err);
        @(negedge clk);
        paddr   = addr;
        pwdata  = wdata;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`SB_ADDR_W-1:0] addr, output logic [31:0] rdata,
                            output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        // prdata is combinational, so it settles well before the rising edge
        #(CLK_PERIOD / 4);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // stage one table entry and push it, a refused push must not be expected
    task automatic push_flit(input int idx, input logic reject);
        logic err;
        for (int w = 0; w < `SB_DATA_WORDS; w++) begin
            apb_write(8'(REG_DATA0 + 4 * w), tbl_data[idx][32*w +: 32], err);
        end
        apb_write(REG_DEST, tbl_dest[idx], err);
        if (!reject) begin
            exp_data.push_back(tbl_data[idx]);
            exp_dest.push_back(tbl_dest[idx]);
            exp_last.push_back(tbl_last[idx]);
        end
        apb_write(REG_PUSH, {31'd0, tbl_last[idx]}, err);
        check_bit("pslverr", reject, err);
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((exp_data.size() != 0 || valid) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (exp_data.size() != 0 || valid) begin
            $display("stream did not drain within %0d cycles, %0d flits never arrived",
                     limit, exp_data.size());
            err_count++;
        end
    endtask

    // compares every handshake with the oldest expectation and watches stalls
    task automatic monitor_flits();
        logic        stall_prev;
        logic        hs_prev;
        flit_data_t  hold_data;
        flit_dest_t  hold_dest;
        logic        hold_last;
        stall_prev = 1'b0;
        hs_prev    = 1'b0;
        forever begin
            @(posedge clk);
            if (valid && ready) begin
                if (hs_prev) begin
                    b2b_count++;
                end
                if (exp_data.size() == 0) begin
                    $display("flit with data 0x%h appeared on the stream but none was expected",
                             data);
                    err_count++;
                end else begin
                    check_data("data", exp_data.pop_front(), data);
                    check_dest("dest", exp_dest.pop_front(), dest);
                    check_bit("last", exp_last.pop_front(), last);
                end
            end
            // a stalled flit keeps valid and its payload until it is taken
            if (stall_prev) begin
                check_bit("valid during stall", 1'b1, valid);
                check_data("data during stall", hold_data, data);
                check_dest("dest during stall", hold_dest, dest);
                check_bit("last during stall", hold_last, last);
            end
            stall_prev = valid && !ready;
            hs_prev    = valid && ready;
            hold_data  = data;
            hold_dest  = dest;
            hold_last  = last;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        test_num++;
        if (err_count == err_before) begin
            tests_ok++;
            $display("test %0d %s ok", test_num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s had %0d errors", test_num, name, err_count - err_before);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles and the run did not complete",
                 WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] wr;
        logic        err;
        int          e0;
        int          b2b0;
        int          seed_ret;
        rst_n      = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = 32'd0;
        ready_req  = 1'b0;
        rand_ready = 1'b0;
        err_count  = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        test_num   = 0;
        b2b_count  = 0;
        seed_ret   = $urandom(32'hd8a380de);

        for (int i = 0; i < TBL_N; i++) begin
            for (int w = 0; w < `SB_DATA_WORDS; w++) begin
                tbl_data[i][32*w +: 32] = $urandom();
            end
            tbl_dest[i] = $urandom();
            tbl_last[i] = 1'($urandom());
        end

        fork
            monitor_flits();
        join_none

        // four full clock cycles of reset, released on a falling edge
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        e0 = err_count;
        check_bit("valid", 1'b0, valid);
        check_bit("pready", 1'b1, pready);
        apb_read(REG_STATUS, rd, err);
        check_word("prdata status", 32'h0000_0200, rd);
        check_bit("pslverr", 1'b0, err);
        apb_read(REG_CTRL, rd, err);
        check_word("prdata ctrl", 32'd0, rd);
        finish_test("reset state", e0);

        // preload behind a stalled output so the queue stays deep once ready rises
        e0 = err_count;
        apb_write(REG_CTRL, 32'(MODE_CONTINUOUS), err);
        for (int i = 0; i < 6; i++) begin
            push_flit(i, 1'b0);
        end
        b2b0      = b2b_count;
        ready_req = 1'b1;
        wait_drain(50);
        if (b2b_count - b2b0 != 5) begin
            $display("continuous mode gave %0d back-to-back handshakes instead of 5",
                     b2b_count - b2b0);
            err_count++;
        end
        finish_test("continuous mode", e0);

        e0 = err_count;
        ready_req = 1'b0;
        apb_write(REG_CTRL, 32'(MODE_ALTERNATE), err);
        for (int i = 6; i < 12; i++) begin
            push_flit(i, 1'b0);
        end
        b2b0      = b2b_count;
        ready_req = 1'b1;
        wait_drain(50);
        if (b2b_count != b2b0) begin
            $display("alternate mode completed handshakes on %0d consecutive cycle pairs",
                     b2b_count - b2b0);
            err_count++;
        end
        finish_test("alternate mode", e0);

        e0 = err_count;
        apb_write(REG_CTRL, 32'(MODE_RANDOM), err);
        rand_ready = 1'b1;
        for (int i = 12; i < TBL_N; i++) begin
            push_flit(i, 1'b0);
        end
        wait_drain(400);
        rand_ready = 1'b0;
        finish_test("random mode with random ready", e0);

        // one presented flit plus a full queue, then one push too many
        e0 = err_count;
        ready_req = 1'b0;
        apb_write(REG_CTRL, 32'(MODE_CONTINUOUS), err);
        for (int i = 0; i <= `SB_FIFO_DEPTH; i++) begin
            push_flit(i, 1'b0);
        end
        apb_read(REG_STATUS, rd, err);
        check_word("prdata status", {22'd0, 1'b0, 1'b1, 3'd0, 5'(`SB_FIFO_DEPTH)}, rd);
        push_flit(`SB_FIFO_DEPTH + 1, 1'b1);
        ready_req = 1'b1;
        wait_drain(100);
        finish_test("back-pressure", e0);

        e0 = err_count;
        apb_read(8'h18, rd, err);
        check_word("prdata unmapped", 32'd0, rd);
        check_bit("pslverr", 1'b1, err);
        apb_write(8'h1C, 32'hFFFF_FFFF, err);
        check_bit("pslverr", 1'b1, err);
        // DATA0, DATA1 and DEST sit on consecutive words
        for (int r = 0; r < 3; r++) begin
            wr = $urandom();
            apb_write(8'(REG_DATA0 + 4 * r), wr, err);
            check_bit("pslverr", 1'b0, err);
            apb_read(8'(REG_DATA0 + 4 * r), rd, err);
            check_word("prdata readback", wr, rd);
        end
        finish_test("register errors", e0);

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_ok, tests_bad, err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/sb_rx_stream.sv
/* switchboard stream receiver endpoint
   flits written over APB are queued and leave on a valid/ready stream */
`timescale 1ns/10ps
`default_nettype none
`include "sb_macros.svh"

module sb_rx_stream
    import sb_apb_pkg::*;
    import sb_flit_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire [`SB_ADDR_W-1:0]  paddr,
    input  wire                   psel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  wire [31:0]            pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output flit_data_t            data,
    output flit_dest_t            dest,
    output logic                  last,
    output logic                  valid,
    input  wire                   ready
);

    // register block to queue
    logic                    push;
    flit_data_t              push_data;
    flit_dest_t              push_dest;
    logic                    push_last;
    logic                    full;
    logic [`SB_LEVEL_W-1:0]  level;
    sb_valid_mode_e          valid_mode;

    // queue to pacer
    logic                    pop;
    logic                    empty;
    flit_data_t              head_data;
    flit_dest_t              head_dest;
    logic                    head_last;

    sb_apb_regs regs0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .full       (full),
        .level      (level),
        .push       (push),
        .push_data  (push_data),
        .push_dest  (push_dest),
        .push_last  (push_last),
        .valid_mode (valid_mode)
    );

    sb_flit_fifo fifo0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_data  (push_data),
        .push_dest  (push_dest),
        .push_last  (push_last),
        .pop        (pop),
        .head_data  (head_data),
        .head_dest  (head_dest),
        .head_last  (head_last),
        .empty      (empty),
        .full       (full),
        .level      (level)
    );

    sb_valid_pacer pacer0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_mode (valid_mode),
        .empty      (empty),
        .head_data  (head_data),
        .head_dest  (head_dest),
        .head_last  (head_last),
        .ready      (ready),
        .pop        (pop),
        .data       (data),
        .dest       (dest),
        .last       (last),
        .valid      (valid)
    );

endmodule

`default_nettype wire

// File: logic/sb_valid_pacer.sv
/* output stage of the stream receiver
   loads flits from the queue head into the stream register and paces
   valid by mode, with an LFSR coin for the random mode */
`timescale 1ns/10ps
`default_nettype none
`include "sb_macros.svh"

module sb_valid_pacer
    import sb_apb_pkg::*;
    import sb_flit_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire sb_valid_mode_e  valid_mode,
    input  wire                  empty,
    input  wire flit_data_t      head_data,
    input  wire flit_dest_t      head_dest,
    input  wire                  head_last,
    input  wire                  ready,
    output logic                 pop,
    output flit_data_t           data,
    output flit_dest_t           dest,
    output logic                 last,
    output logic                 valid
);

    // feedback mask for x^16 + x^14 + x^13 + x^11 + 1 in right shift form
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic [15:0] lfsr_q;
    logic        coin;
    logic        handshake;
    logic        want_load;
    logic        load;

    assign coin      = lfsr_q[0];
    assign handshake = valid & ready;

    // a new flit may only be taken when the register is free or draining
    always_comb begin
        want_load = 1'b0;
        if (handshake || !valid) begin
            case (valid_mode)
                // alternate mode forces one idle cycle after each transfer
                MODE_ALTERNATE: want_load = !valid;
                MODE_RANDOM:    want_load = coin;
                default:        want_load = 1'b1;
            endcase
        end
    end

    assign load = want_load & ~empty;
    assign pop  = load;

    // the coin keeps running whether or not it is consulted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= `SB_LFSR_SEED;
        end else begin
            lfsr_q <= {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 16'h0000);
        end
    end

    // a load wins over the handshake so continuous mode keeps valid high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (handshake) begin
            valid <= 1'b0;
        end
    end

    // payload only changes on a load, which holds it during a stall
    always_ff @(posedge clk) begin
        if (load) begin
            data <= head_data;
            dest <= head_dest;
            last <= head_last;
        end
    end

endmodule

`default_nettype wire

// File: logic/sb_flit_fifo.sv
/* flit queue of the stream receiver
   circular buffer with a first-word-fall-through head and a level count */
`timescale 1ns/10ps
`default_nettype none
`include "sb_macros.svh"

module sb_flit_fifo
    import sb_flit_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    push,
    input  wire flit_data_t        push_data,
    input  wire flit_dest_t        push_dest,
    input  wire                    push_last,
    input  wire                    pop,
    output flit_data_t             head_data,
    output flit_dest_t             head_dest,
    output logic                   head_last,
    output logic                   empty,
    output logic                   full,
    output logic [`SB_LEVEL_W-1:0] level
);

    localparam int PTR_W = $clog2(`SB_FIFO_DEPTH);
    localparam logic [`SB_LEVEL_W-1:0] DEPTH_L = `SB_FIFO_DEPTH;

    flit_data_t              mem_data [`SB_FIFO_DEPTH];
    flit_dest_t              mem_dest [`SB_FIFO_DEPTH];
    logic                    mem_last [`SB_FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [`SB_LEVEL_W-1:0]  count;
    logic                    do_push;
    logic                    do_pop;

    assign empty = (count == '0);
    assign full  = (count == DEPTH_L);
    assign level = count;

    // guard both sides so a stray request cannot corrupt the pointers
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the level unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_data[wr_ptr] <= push_data;
            mem_dest[wr_ptr] <= push_dest;
            mem_last[wr_ptr] <= push_last;
        end
    end

    // oldest entry is visible without a read cycle
    assign head_data = mem_data[rd_ptr];
    assign head_dest = mem_dest[rd_ptr];
    assign head_last = mem_last[rd_ptr];

endmodule

`default_nettype wire

// File: logic/sb_apb_regs.sv
/* APB register block of the stream receiver
   stages flit fields, pushes flits into the queue, holds the valid mode
   and reports the queue status */
`timescale 1ns/10ps
`default_nettype none
`include "sb_macros.svh"

module sb_apb_regs
    import sb_apb_pkg::*;
    import sb_flit_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire [`SB_ADDR_W-1:0]   paddr,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire [31:0]             pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  wire                    full,
    input  wire [`SB_LEVEL_W-1:0]  level,
    output logic                   push,
    output flit_data_t             push_data,
    output flit_dest_t             push_dest,
    output logic                   push_last,
    output sb_valid_mode_e         valid_mode
);

    // index of the upper data word, folds to zero for a 32 bit flit
    localparam int unsigned HI_WORD = (`SB_DATA_WORDS > 1) ? 1 : 0;

    logic [31:0]     data_q [`SB_DATA_WORDS];
    flit_dest_t      dest_q;
    sb_valid_mode_e  mode_q;
    logic            access;
    logic            wr_en;
    logic            rd_en;
    logic            mapped;
    logic            push_hit;
    logic            empty;
    logic [31:0]     status;
    logic [31:0]     rd_word;

    // no wait states so the access phase is always one cycle
    assign pready = 1'b1;
    assign access = psel & penable;
    assign wr_en  = access & pwrite;
    assign rd_en  = access & ~pwrite;

    // status word carries level in 4:0, full in 8 and empty in 9
    assign empty  = (level == '0);
    assign status = {22'd0, empty, full, 3'd0, level};

    // address decode and read mux share one case
    always_comb begin
        mapped  = 1'b1;
        rd_word = 32'd0;
        case (paddr)
            REG_CTRL:   rd_word = {30'd0, mode_q};
            REG_DATA0:  rd_word = data_q[0];
            REG_DATA1: begin
                // the second data word only exists for flits wider than 32
                mapped  = (`SB_DATA_WORDS > 1);
                rd_word = mapped ? data_q[HI_WORD] : 32'd0;
            end
            REG_DEST:   rd_word = dest_q;
            REG_PUSH:   rd_word = 32'd0;
            REG_STATUS: rd_word = status;
            default:    mapped = 1'b0;
        endcase
    end

    // read data is only driven during a read access phase
    assign prdata = rd_en ? rd_word : 32'd0;

    // a push into a full queue is refused and flagged as a slave error
    assign push_hit = wr_en && (paddr == REG_PUSH);
    assign push     = push_hit & ~full;
    assign pslverr  = access & (~mapped | (push_hit & full));

    // the pushed flit is the staged fields plus the last bit of this write
    assign push_last = pwdata[0];
    assign push_dest = dest_q;
    always_comb begin
        for (int i = 0; i < `SB_DATA_WORDS; i++) begin
            push_data[32*i +: 32] = data_q[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= MODE_ALTERNATE;
        end else if (wr_en && (paddr == REG_CTRL)) begin
            mode_q <= sb_valid_mode_e'(pwdata[1:0]);
        end
    end

    // staged flit fields keep their value until written again
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (paddr)
                REG_DATA0: data_q[0] <= pwdata;
                REG_DATA1: begin
                    if (`SB_DATA_WORDS > 1) begin
                        data_q[HI_WORD] <= pwdata;
                    end
                end
                REG_DEST:  dest_q <= pwdata;
                default:   ;
            endcase
        end
    end

    assign valid_mode = mode_q;

endmodule

`default_nettype wire

// File: logic/sb_flit_pkg.sv
/* stream side types of the stream receiver
   field vectors of one flit as it moves through the queue and out */
`default_nettype none
`include "sb_macros.svh"

package sb_flit_pkg;

    // payload word of a flit
    typedef logic [`SB_DW-1:0] flit_data_t;

    // destination tag that travels next to the payload
    typedef logic [`SB_DEST_W-1:0] flit_dest_t;

    // the last flag is a single bit and needs no type of its own

endpackage

`default_nettype wire

// File: logic/sb_apb_pkg.sv
/* register side types of the stream receiver
   APB register offsets and the output valid pacing modes */
`default_nettype none
`include "sb_macros.svh"

package sb_apb_pkg;

    // word aligned register offsets on the APB slave
    typedef enum logic [`SB_ADDR_W-1:0] {
        REG_CTRL   = `SB_REG_CTRL,
        REG_DATA0  = `SB_REG_DATA0,
        REG_DATA1  = `SB_REG_DATA1,
        REG_DEST   = `SB_REG_DEST,
        REG_PUSH   = `SB_REG_PUSH,
        REG_STATUS = `SB_REG_STATUS
    } sb_reg_addr_e;

    // how the stream output paces valid, an unlisted 3 acts as continuous
    typedef enum logic [1:0] {
        MODE_ALTERNATE  = 2'd0,
        MODE_CONTINUOUS = 2'd1,
        MODE_RANDOM     = 2'd2
    } sb_valid_mode_e;

endpackage

`default_nettype wire

// File: logic/sb_macros.svh
/* switchboard stream receiver constants
   flit widths, queue depth, coin LFSR seed and the APB register map */
`ifndef SB_MACROS_SVH
`define SB_MACROS_SVH

// flit data width, kept to a multiple of 32 so it maps onto whole APB words
`define SB_DW         64
`define SB_DATA_WORDS (`SB_DW / 32)
`define SB_DEST_W     32

// queue depth must be a power of two and the level needs one extra bit
`define SB_FIFO_DEPTH 8
`define SB_LEVEL_W    5

// any nonzero value works as the LFSR start state
`define SB_LFSR_SEED  16'hACE1

`define SB_ADDR_W     8
`define SB_REG_CTRL   'h00
`define SB_REG_DATA0  'h04
`define SB_REG_DATA1  'h08
`define SB_REG_DEST   'h0C
`define SB_REG_PUSH   'h10
`define SB_REG_STATUS 'h14

`endif
